// File: common/conv_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Shared sizes and types of the row convolution engine
////////////////////////////////////////////////////////////////////////

package conv_pkg;

    // Row and kernel geometry
    localparam int ROW_LEN = 10;
    localparam int KSIZE   = 3;
    localparam int PIX_W   = 8;
    localparam int WGT_W   = 8;

    // Valid window positions per row
    localparam int OUT_LEN = ROW_LEN - KSIZE + 1;

    // Full product of one pixel and one weight
    localparam int PROD_W = PIX_W + WGT_W;
    // Sum of KSIZE products along one row
    localparam int RSUM_W = PROD_W + $clog2(KSIZE);
    // Sum of KSIZE row sums, whole window
    localparam int WSUM_W = RSUM_W + $clog2(KSIZE);

    // Weight port addressing
    localparam int WADDR_W = 4;
    localparam int NUM_WGT = KSIZE * KSIZE;
    // Row or column index inside the kernel
    localparam int KIDX_W  = $clog2(KSIZE);

    // Pixel 0 sits in the low bits
    typedef logic [ROW_LEN-1:0][PIX_W-1:0] pixel_row_t;
    typedef logic [KSIZE-1:0][WGT_W-1:0]   kernel_row_t;
    // Kernel row 0 pairs with the oldest buffered row
    typedef kernel_row_t [KSIZE-1:0]       kernel_t;

    typedef logic [OUT_LEN-1:0][RSUM_W-1:0] rsum_row_t;
    typedef logic [OUT_LEN-1:0][WSUM_W-1:0] out_row_t;

    // One weight write, addr k maps to row k/3, column k%3
    typedef struct packed {
        logic               we;
        logic [WADDR_W-1:0] addr;
        logic [WGT_W-1:0]   data;
    } weight_wr_t;

    // Row buffer filling or streaming full windows
    typedef enum logic {
        FILL,
        STREAM
    } window_state_e;

endpackage

`default_nettype wire

// File: verilog/unsigned_adder_tree.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Balanced pairwise adder tree, unsigned, fully combinational
////////////////////////////////////////////////////////////////////////

module unsigned_adder_tree #(
    parameter int N      = 3,
    parameter int DATA_W = 16
) (
    input  wire logic [N-1:0][DATA_W-1:0]      addends,
    output logic      [DATA_W+$clog2(N)-1:0]   sum
);

    // One extra bit per level of pairing
    localparam int LEVELS = $clog2(N);

    // Nodes left at a given level
    function automatic int level_count(int lvl);
        int cnt;
        cnt = N;
        for (int k = 0; k < lvl; k++) begin
            cnt = (cnt + 1) / 2;
        end
        return cnt;
    endfunction

    genvar lvl, k;
    generate
        for (lvl = 0; lvl <= LEVELS; lvl++) begin : g_level
            localparam int CNT = level_count(lvl);
            localparam int W   = DATA_W + lvl;
            logic [CNT-1:0][W-1:0] node;

            if (lvl == 0) begin : g_leaf
                assign node = addends;
            end else begin : g_sum
                localparam int PREV = level_count(lvl - 1);
                for (k = 0; k < CNT; k++) begin : g_node
                    if (2 * k + 1 < PREV) begin : g_pair
                        assign node[k] = {1'b0, g_level[lvl-1].node[2*k]}
                                       + {1'b0, g_level[lvl-1].node[2*k+1]};
                    end else begin : g_carry
                        // Odd leftover moves up unchanged
                        assign node[k] = {1'b0, g_level[lvl-1].node[2*k]};
                    end
                end
            end
        end
    endgenerate

    // Root of the tree
    assign sum = g_level[LEVELS].node[0];

endmodule

`default_nettype wire

// File: verilog/vector_conv.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////
// 1D convolution of one pixel row with one kernel row
////////////////////////////////////////////////////////////////////////

module vector_conv (
    input  wire conv_pkg::pixel_row_t  pixels,
    input  wire conv_pkg::kernel_row_t weights,
    output conv_pkg::rsum_row_t        psums
);

    import conv_pkg::*;

    genvar i, j;
    generate
        // One tree per output position
        for (i = 0; i < OUT_LEN; i++) begin : g_pos
            // Products feeding position i
            logic [KSIZE-1:0][PROD_W-1:0] prods;

            for (j = 0; j < KSIZE; j++) begin : g_tap
                // Widened to PROD_W before the multiply
                assign prods[j] = PROD_W'(pixels[i+j]) * PROD_W'(weights[j]);
            end

            // Reduce the KSIZE products
            unsigned_adder_tree #(
                .N      (KSIZE),
                .DATA_W (PROD_W)
            ) adder_tree_inst (
                .addends (prods),
                .sum     (psums[i])
            );
        end
    endgenerate

endmodule

`default_nettype wire

// File: verilog/weight_regs.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Kernel weight registers, written one weight per cycle
////////////////////////////////////////////////////////////////////////

module weight_regs (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire conv_pkg::weight_wr_t weight_wr,
    output conv_pkg::kernel_t         kernel
);

    import conv_pkg::*;

    // Decoded kernel position
    logic [KIDX_W-1:0] wr_row;
    logic [KIDX_W-1:0] wr_col;
    // Address inside the 3x3 kernel
    logic              wr_hit;

    always_comb begin
        wr_row = KIDX_W'(weight_wr.addr / KSIZE);
        wr_col = KIDX_W'(weight_wr.addr % KSIZE);
        // Addresses 9 to 15 fall outside the kernel
        wr_hit = weight_wr.we && (weight_wr.addr < WADDR_W'(NUM_WGT));
    end

    // Nine weights, all zero after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kernel <= '0;
        end else if (wr_hit) begin
            kernel[wr_row][wr_col] <= weight_wr.data;
        end
    end

endmodule

`default_nettype wire

// File: row_window/row_buffer.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Three-row window buffer
////////////////////////////////////////////////////////////////////////

module row_buffer (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 frame_start,
    input  wire logic                 row_valid,
    input  wire conv_pkg::pixel_row_t pixel_row,
    // Index 0 holds the oldest row
    output conv_pkg::pixel_row_t [conv_pkg::KSIZE-1:0] win_rows,
    output logic                      win_ready
);

    import conv_pkg::*;

    window_state_e     state;
    // Rows seen so far in this frame, while filling
    logic [KIDX_W-1:0] fill_cnt;

    ////////////////////////////////////////////////////////////////////
    // Row shift register
    ////////////////////////////////////////////////////////////////////

    // Newest row enters at the top index
    always_ff @(posedge clk) begin
        if (row_valid) begin
            for (int r = 0; r < KSIZE - 1; r++) begin
                win_rows[r] <= win_rows[r+1];
            end
            win_rows[KSIZE-1] <= pixel_row;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Fill control
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= FILL;
            fill_cnt  <= '0;
            win_ready <= 1'b0;
        end else begin
            // Single-cycle strobe by default
            win_ready <= 1'b0;
            if (frame_start) begin
                // Row in the same cycle counts as row one of the new frame
                state    <= FILL;
                fill_cnt <= row_valid ? KIDX_W'(1) : '0;
            end else if (row_valid) begin
                if (state == STREAM) begin
                    win_ready <= 1'b1;
                end else if (fill_cnt == KIDX_W'(KSIZE - 1)) begin
                    // Third row completes the first window
                    state     <= STREAM;
                    win_ready <= 1'b1;
                end else begin
                    fill_cnt <= fill_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: row_window/window_conv.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////
// 3x3 window convolution with registered output row
////////////////////////////////////////////////////////////////////////

module window_conv (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire conv_pkg::pixel_row_t [conv_pkg::KSIZE-1:0] win_rows,
    input  wire logic                 win_ready,
    input  wire conv_pkg::kernel_t    kernel,
    output conv_pkg::out_row_t        out_row,
    output logic                      out_valid
);

    import conv_pkg::*;

    // Per-row partial sums, oldest row first
    rsum_row_t [KSIZE-1:0] row_sums;
    // Full window sums before the output register
    out_row_t              win_sum;

    genvar r, i;
    generate
        // Each buffered row against its kernel row
        for (r = 0; r < KSIZE; r++) begin : g_row
            vector_conv vector_conv_inst (
                .pixels  (win_rows[r]),
                .weights (kernel[r]),
                .psums   (row_sums[r])
            );
        end

        // Column stage adds the three row sums per position
        for (i = 0; i < OUT_LEN; i++) begin : g_col
            logic [KSIZE-1:0][RSUM_W-1:0] col_addends;

            for (r = 0; r < KSIZE; r++) begin : g_gather
                assign col_addends[r] = row_sums[r][i];
            end

            unsigned_adder_tree #(
                .N      (KSIZE),
                .DATA_W (RSUM_W)
            ) col_tree_inst (
                .addends (col_addends),
                .sum     (win_sum[i])
            );
        end
    endgenerate

    // Output row captured only for a ready window
    always_ff @(posedge clk) begin
        if (win_ready) begin
            out_row <= win_sum;
        end
    end

    // Strobe trails win_ready by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= win_ready;
        end
    end

endmodule

`default_nettype wire

// File: verilog/conv2d_row_engine.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Row-streaming 2D convolution engine, top level
////////////////////////////////////////////////////////////////////////

module conv2d_row_engine (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire conv_pkg::weight_wr_t weight_wr,
    input  wire logic                 frame_start,
    input  wire logic                 row_valid,
    input  wire conv_pkg::pixel_row_t pixel_row,
    output logic                      out_valid,
    output conv_pkg::out_row_t        out_row
);

    import conv_pkg::*;

    kernel_t                kernel;
    pixel_row_t [KSIZE-1:0] win_rows;
    logic                   win_ready;

    // Kernel storage
    weight_regs weight_regs_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .weight_wr (weight_wr),
        .kernel    (kernel)
    );

    // Last three rows
    row_buffer row_buffer_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .row_valid   (row_valid),
        .pixel_row   (pixel_row),
        .win_rows    (win_rows),
        .win_ready   (win_ready)
    );

    // Window arithmetic and output register
    window_conv window_conv_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_rows  (win_rows),
        .win_ready (win_ready),
        .kernel    (kernel),
        .out_row   (out_row),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    localparam time HALF_PERIOD = 4ns;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset held over two rising edges, released away from them
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/tb_conv2d_row_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conv2d_row_engine;

    import conv_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Stimulus table layout
    //////////////////////////////////////////////////////////////////////

    // Zero kernel, delta, random back-to-back, random gaps, all ones
    localparam int NUM_SEC = 5;
    localparam int SEC_START [NUM_SEC+1] = '{0, 8, 18, 30, 46, 54};
    localparam int TBL_LEN   = SEC_START[NUM_SEC];
    // Two idle cycles, nine writes, one stray write, one release
    localparam int WR_CYCLES = 13;
    localparam int CYC_LIMIT = TBL_LEN + (NUM_SEC - 1) * WR_CYCLES + 50;
    localparam int CHK_W     = $bits(out_row_t);
    localparam int unsigned SEED = 32'h9e5d;

    typedef struct packed {
        logic       frame_start;
        logic       row_valid;
        pixel_row_t row;
    } stim_t;

    logic       clk;
    logic       rst_n;
    weight_wr_t weight_wr;
    logic       frame_start;
    logic       row_valid;
    pixel_row_t pixel_row;
    logic       out_valid;
    out_row_t   out_row;

    stim_t                  stim_tbl [TBL_LEN];
    kernel_t                kern_tbl [NUM_SEC];
    // Reference state of the window
    pixel_row_t [KSIZE-1:0] model_rows;
    kernel_t                model_kern;
    int                     model_cnt;
    // Pending outputs and the cycle each is due
    out_row_t               exp_rows [$];
    int                     exp_due [$];
    int                     cyc = 0;

    clk_gen clk_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    conv2d_row_engine conv2d_row_engine_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .weight_wr   (weight_wr),
        .frame_start (frame_start),
        .row_valid   (row_valid),
        .pixel_row   (pixel_row),
        .out_valid   (out_valid),
        .out_row     (out_row)
    );

    //////////////////////////////////////////////////////////////////////
    // Reporting and reference model
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string name, logic [CHK_W-1:0] actual,
                               logic [CHK_W-1:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    // Sum i over rows r, columns j of pixel i+j times weight r,j
    function automatic out_row_t expected_row(pixel_row_t [KSIZE-1:0] rows, kernel_t kern);
        out_row_t    res;
        logic [31:0] acc;
        for (int i = 0; i < OUT_LEN; i++) begin
            acc = '0;
            for (int r = 0; r < KSIZE; r++) begin
                for (int j = 0; j < KSIZE; j++) begin
                    acc = acc + 32'(rows[r][i+j]) * 32'(kern[r][j]);
                end
            end
            res[i] = acc[WSUM_W-1:0];
        end
        return res;
    endfunction

    function automatic pixel_row_t random_row();
        pixel_row_t row;
        for (int p = 0; p < ROW_LEN; p++) begin
            row[p] = 8'($urandom);
        end
        return row;
    endfunction

    // Wait for a falling edge, then check what the DUT shows
    task automatic step_cycle();
        logic due;
        @(negedge clk);
        due = (exp_due.size() > 0) && (exp_due[0] == cyc);
        check_value("out_valid", CHK_W'(out_valid), CHK_W'(due));
        if (due) begin
            check_value("out_row", out_row, exp_rows[0]);
            void'(exp_rows.pop_front());
            void'(exp_due.pop_front());
        end
    endtask

    task automatic apply_entry(stim_t st);
        frame_start = st.frame_start;
        row_valid   = st.row_valid;
        pixel_row   = st.row;
        if (st.row_valid) begin
            model_rows = {st.row, model_rows[KSIZE-1:1]};
        end
        if (st.frame_start) begin
            model_cnt = st.row_valid ? 1 : 0;
        end else if (st.row_valid) begin
            if (model_cnt < KSIZE) model_cnt++;
            // Window completes; output 2 edges after the sampling edge
            if (model_cnt == KSIZE) begin
                exp_rows.push_back(expected_row(model_rows, model_kern));
                exp_due.push_back(cyc + 2);
            end
        end
    endtask

    task automatic load_kernel(kernel_t kern);
        // Last row of the previous section is sampled first
        step_cycle();
        frame_start = 1'b0;
        row_valid   = 1'b0;
        // Let the window still in flight leave
        step_cycle();
        for (int k = 0; k <= NUM_WGT; k++) begin
            step_cycle();
            weight_wr.we   = 1'b1;
            // Top address is outside the kernel and must change nothing
            weight_wr.addr = (k < NUM_WGT) ? WADDR_W'(k) : '1;
            weight_wr.data = (k < NUM_WGT) ? kern[k/KSIZE][k%KSIZE] : 8'hff;
        end
        step_cycle();
        weight_wr  = '0;
        model_kern = kern;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Timeout and main sequence
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYC_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYC_LIMIT);
            abort_run();
        end
    end

    initial begin
        void'($urandom(SEED));
        weight_wr   = '0;
        frame_start = 1'b0;
        row_valid   = 1'b0;
        pixel_row   = '0;
        model_rows  = '0;
        model_kern  = '0;
        model_cnt   = 0;

        kern_tbl[0] = '0;
        kern_tbl[1] = '0;
        kern_tbl[1][1][1] = 8'd1;
        for (int s = 2; s < 4; s++) begin
            for (int k = 0; k < NUM_WGT; k++) begin
                kern_tbl[s][k/KSIZE][k%KSIZE] = 8'($urandom);
            end
        end
        kern_tbl[4] = '1;

        // New frame at each section start, plus one in the middle of the gap section
        for (int s = 0; s < NUM_SEC; s++) begin
            for (int e = SEC_START[s]; e < SEC_START[s+1]; e++) begin
                stim_tbl[e].frame_start = (e == SEC_START[s]) || (s == 3 && e == SEC_START[s] + 8);
                stim_tbl[e].row_valid   = (s == 3) ? ($urandom_range(0, 2) != 0) : 1'b1;
                stim_tbl[e].row         = (s == 4) ? '1 : random_row();
            end
        end

        wait (rst_n === 1'b1);
        for (int s = 0; s < NUM_SEC; s++) begin
            // Section 0 runs on the weights left by reset
            if (s > 0) load_kernel(kern_tbl[s]);
            for (int e = SEC_START[s]; e < SEC_START[s+1]; e++) begin
                step_cycle();
                apply_entry(stim_tbl[e]);
            end
        end

        step_cycle();
        frame_start = 1'b0;
        row_valid   = 1'b0;
        while (exp_due.size() > 0) step_cycle();
        // No stray strobes once drained
        repeat (3) step_cycle();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: conv2d_row_engine.f
common/conv_pkg.sv
verilog/unsigned_adder_tree.sv
verilog/vector_conv.sv
verilog/weight_regs.sv
row_window/row_buffer.sv
row_window/window_conv.sv
verilog/conv2d_row_engine.sv
sim/clk_gen.sv
sim/tb_conv2d_row_engine.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status follows the result

cd "$(dirname "$0")" || exit 1

sim_out="$(verilator --binary --timing -j 0 \
        --top-module tb_conv2d_row_engine \
        -f conv2d_row_engine.f \
        -Mdir obj_dir \
    && ./obj_dir/Vtb_conv2d_row_engine 2>&1)"

echo "$sim_out"

echo "$sim_out" | grep -q "^Verification passed$" \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }
